// ==== hw/aluCmdPkg.sv ====
package aluCmdPkg;

  // width of the external command field
  localparam int cmdWidth = 3;

  // command encoding seen on the ALU input port
  typedef enum logic [cmdWidth-1:0] {
    // arithmetic
    cmdAdd  = 3'd0,
    cmdSub  = 3'd1,
    // bitwise exclusive or
    cmdXor  = 3'd2,
    // signed set-less-than, result is 0 or 1
    cmdSlt  = 3'd3,
    // and family
    cmdAnd  = 3'd4,
    cmdNand = 3'd5,
    // or family
    cmdNor  = 3'd6,
    cmdOr   = 3'd7
  } aluCmdT;

endpackage

// ==== hw/aluCtrlPkg.sv ====
package aluCtrlPkg;

  // width of the functional unit select
  localparam int unitSelWidth = 3;

  // which functional unit drives the execute stage result
  typedef enum logic [unitSelWidth-1:0] {
    // ripple-carry adder/subtractor, only unit with live flags
    unitAddSub  = 3'd0,
    // bitwise xor
    unitXor     = 3'd1,
    // sign of A minus B, corrected by overflow
    unitSlt     = 3'd2,
    // and, optionally inverted
    unitAndNand = 3'd3,
    // nor, optionally inverted
    unitNorOr   = 3'd4
  } unitSelT;

endpackage

// ==== hw/aluAdder.sv ====
`timescale 1ns/1ps

module aluAdder #(
  parameter int dataWidth = 32
) (
  input  logic [dataWidth-1:0] operandA,
  input  logic [dataWidth-1:0] operandB,
  input  logic                 subtract,
  output logic [dataWidth-1:0] sum,
  output logic                 carryOut,
  output logic                 overflow
);

  // carry[i] is the carry into bit i
  logic [dataWidth:0]   carry;
  logic [dataWidth-1:0] bInv;
  logic [dataWidth-1:0] halfSum;

  // subtract adds the +1 of two's complement
  assign carry[0] = subtract;

  genvar i;
  generate
    for (i = 0; i < dataWidth; i++) begin : gSlice
      // B is inverted per slice for subtraction
      assign bInv[i] = operandB[i] ^ subtract;

      // full adder equations
      assign halfSum[i]  = operandA[i] ^ bInv[i];
      assign sum[i]      = halfSum[i] ^ carry[i];
      assign carry[i+1]  = (operandA[i] & bInv[i]) | (halfSum[i] & carry[i]);
    end
  endgenerate

  assign carryOut = carry[dataWidth];

  // signed overflow when carry into and out of the sign bit differ
  assign overflow = carry[dataWidth] ^ carry[dataWidth-1];

endmodule

// ==== hw/aluDecode.sv ====
`timescale 1ns/1ps

module aluDecode
  import aluCmdPkg::*;
  import aluCtrlPkg::*;
#(
  parameter int dataWidth = 32
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 opValid,
  input  aluCmdT               command,
  input  logic [dataWidth-1:0] operandA,
  input  logic [dataWidth-1:0] operandB,
  output logic                 decValid,
  output unitSelT              decUnitSel,
  output logic                 decInvertB,
  output logic                 decInvertResult,
  output logic [dataWidth-1:0] decOperandA,
  output logic [dataWidth-1:0] decOperandB
);

  unitSelT unitSel;
  logic    invertB;
  logic    invertResult;

  // command to control lookup
  always_comb begin
    unitSel      = unitAddSub;
    invertB      = 1'b0;
    invertResult = 1'b0;
    case (command)
      cmdAdd:  unitSel = unitAddSub;
      cmdSub: begin
        unitSel = unitAddSub;
        invertB = 1'b1;
      end
      cmdXor:  unitSel = unitXor;
      cmdSlt:  unitSel = unitSlt;
      cmdAnd:  unitSel = unitAndNand;
      cmdNand: begin
        unitSel      = unitAndNand;
        invertResult = 1'b1;
      end
      // nor is the raw gate output, or inverts it back
      cmdNor:  unitSel = unitNorOr;
      cmdOr: begin
        unitSel      = unitNorOr;
        invertResult = 1'b1;
      end
      default: unitSel = unitAddSub;
    endcase
  end

  // control registers
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      decValid        <= 1'b0;
      decUnitSel      <= unitAddSub;
      decInvertB      <= 1'b0;
      decInvertResult <= 1'b0;
    end else begin
      decValid <= opValid;
      if (opValid) begin
        decUnitSel      <= unitSel;
        decInvertB      <= invertB;
        decInvertResult <= invertResult;
      end
    end
  end

  // operands travel with their controls
  always_ff @(posedge clk) begin
    if (opValid) begin
      decOperandA <= operandA;
      decOperandB <= operandB;
    end
  end

  assert property (@(posedge clk) disable iff (!arstN)
    decValid |-> !$isunknown(decUnitSel));

endmodule

// ==== hw/aluExecute.sv ====
`timescale 1ns/1ps

module aluExecute
  import aluCtrlPkg::*;
#(
  parameter int dataWidth = 32
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 decValid,
  input  unitSelT              decUnitSel,
  input  logic                 decInvertB,
  input  logic                 decInvertResult,
  input  logic [dataWidth-1:0] decOperandA,
  input  logic [dataWidth-1:0] decOperandB,
  output logic                 exeValid,
  output unitSelT              exeUnitSel,
  output logic [dataWidth-1:0] exeResult,
  output logic                 exeCarry,
  output logic                 exeOverflow
);

  logic [dataWidth-1:0] addSum;
  logic                 addCarry;
  logic                 addOverflow;
  logic [dataWidth-1:0] sltDiff;
  logic                 sltOverflow;
  logic                 sltBit;
  logic [dataWidth-1:0] xorResult;
  logic [dataWidth-1:0] andResult;
  logic [dataWidth-1:0] norResult;
  logic [dataWidth-1:0] sltResult;
  logic [dataWidth-1:0] selResult;

  // add/sub unit
  aluAdder #(
    .dataWidth(dataWidth)
  ) i_addSub (
    .operandA(decOperandA),
    .operandB(decOperandB),
    .subtract(decInvertB),
    .sum     (addSum),
    .carryOut(addCarry),
    .overflow(addOverflow)
  );

  // dedicated subtractor for slt
  aluAdder #(
    .dataWidth(dataWidth)
  ) i_sltSub (
    .operandA(decOperandA),
    .operandB(decOperandB),
    .subtract(1'b1),
    .sum     (sltDiff),
    .carryOut(),
    .overflow(sltOverflow)
  );

  // sign of the difference, fixed up when it overflowed
  assign sltBit    = sltDiff[dataWidth-1] ^ sltOverflow;
  assign sltResult = {{(dataWidth-1){1'b0}}, sltBit};

  assign xorResult = decOperandA ^ decOperandB;
  assign andResult = (decOperandA & decOperandB) ^ {dataWidth{decInvertResult}};
  assign norResult = ~(decOperandA | decOperandB) ^ {dataWidth{decInvertResult}};

  // result mux
  always_comb begin
    case (decUnitSel)
      unitAddSub:  selResult = addSum;
      unitXor:     selResult = xorResult;
      unitSlt:     selResult = sltResult;
      unitAndNand: selResult = andResult;
      unitNorOr:   selResult = norResult;
      default:     selResult = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exeValid   <= 1'b0;
      exeUnitSel <= unitAddSub;
    end else begin
      exeValid <= decValid;
      if (decValid) begin
        exeUnitSel <= decUnitSel;
      end
    end
  end

  // flags are passed raw, the result stage masks them
  always_ff @(posedge clk) begin
    if (decValid) begin
      exeResult   <= selResult;
      exeCarry    <= addCarry;
      exeOverflow <= addOverflow;
    end
  end

  // only SUB inverts B, so this ties the decode table to the adder
  assert property (@(posedge clk) disable iff (!arstN)
    (decValid && decInvertB) |-> (decUnitSel == unitAddSub));

endmodule

// ==== hw/aluResult.sv ====
`timescale 1ns/1ps

module aluResult
  import aluCtrlPkg::*;
#(
  parameter int dataWidth = 32
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 exeValid,
  input  unitSelT              exeUnitSel,
  input  logic [dataWidth-1:0] exeResult,
  input  logic                 exeCarry,
  input  logic                 exeOverflow,
  output logic                 resultValid,
  output logic [dataWidth-1:0] result,
  output logic                 carryOut,
  output logic                 overflow,
  output logic                 zero
);

  logic isArith;
  logic resultZero;
  logic carryMasked;
  logic overflowMasked;
  logic zeroMasked;

  assign resultZero = ~|exeResult;

  // flags only mean something for add and sub
  assign isArith        = (exeUnitSel == unitAddSub);
  assign carryMasked    = exeCarry & isArith;
  assign overflowMasked = exeOverflow & isArith;
  assign zeroMasked     = resultZero & isArith;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resultValid <= 1'b0;
      result      <= '0;
      carryOut    <= 1'b0;
      overflow    <= 1'b0;
      zero        <= 1'b0;
    end else begin
      // one-cycle strobe, outputs hold in between
      resultValid <= exeValid;
      if (exeValid) begin
        result   <= exeResult;
        carryOut <= carryMasked;
        overflow <= overflowMasked;
        zero     <= zeroMasked;
      end
    end
  end

  // every strobe out comes from exactly one strobe in
  assert property (@(posedge clk) disable iff (!arstN)
    resultValid == $past(exeValid));

endmodule

// ==== hw/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit
  import aluCmdPkg::*;
  import aluCtrlPkg::*;
#(
  parameter int dataWidth = 32
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 opValid,
  input  aluCmdT               command,
  input  logic [dataWidth-1:0] operandA,
  input  logic [dataWidth-1:0] operandB,
  output logic                 resultValid,
  output logic [dataWidth-1:0] result,
  output logic                 carryOut,
  output logic                 overflow,
  output logic                 zero
);

  // decode to execute
  logic                 decValid;
  unitSelT              decUnitSel;
  logic                 decInvertB;
  logic                 decInvertResult;
  logic [dataWidth-1:0] decOperandA;
  logic [dataWidth-1:0] decOperandB;

  // execute to result
  logic                 exeValid;
  unitSelT              exeUnitSel;
  logic [dataWidth-1:0] exeResult;
  logic                 exeCarry;
  logic                 exeOverflow;

  aluDecode #(
    .dataWidth(dataWidth)
  ) i_aluDecode (
    .clk            (clk),
    .arstN          (arstN),
    .opValid        (opValid),
    .command        (command),
    .operandA       (operandA),
    .operandB       (operandB),
    .decValid       (decValid),
    .decUnitSel     (decUnitSel),
    .decInvertB     (decInvertB),
    .decInvertResult(decInvertResult),
    .decOperandA    (decOperandA),
    .decOperandB    (decOperandB)
  );

  aluExecute #(
    .dataWidth(dataWidth)
  ) i_aluExecute (
    .clk            (clk),
    .arstN          (arstN),
    .decValid       (decValid),
    .decUnitSel     (decUnitSel),
    .decInvertB     (decInvertB),
    .decInvertResult(decInvertResult),
    .decOperandA    (decOperandA),
    .decOperandB    (decOperandB),
    .exeValid       (exeValid),
    .exeUnitSel     (exeUnitSel),
    .exeResult      (exeResult),
    .exeCarry       (exeCarry),
    .exeOverflow    (exeOverflow)
  );

  aluResult #(
    .dataWidth(dataWidth)
  ) i_aluResult (
    .clk        (clk),
    .arstN      (arstN),
    .exeValid   (exeValid),
    .exeUnitSel (exeUnitSel),
    .exeResult  (exeResult),
    .exeCarry   (exeCarry),
    .exeOverflow(exeOverflow),
    .resultValid(resultValid),
    .result     (result),
    .carryOut   (carryOut),
    .overflow   (overflow),
    .zero       (zero)
  );

endmodule

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ps

module tbClock #(
  parameter int periodNs    = 8,
  parameter int resetCycles = 8
) (
  output logic clk,
  output logic arstN
);

  initial begin
    clk = 1'b0;
    forever begin
      #(periodNs / 2) clk = ~clk;
    end
  end

  // release just after an edge, away from the sampling point
  initial begin
    arstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1;
    arstN = 1'b1;
  end

endmodule

// ==== testbench/tbAluUnit.sv ====
`timescale 1ns/1ps

module tbAluUnit
  import aluCmdPkg::*;
();

  localparam int dataWidth  = 32;
  localparam int msb        = dataWidth - 1;
  localparam int numOps     = 400;
  localparam int drainLimit = 20;
  localparam int resetLimit = 20;
  localparam logic [dataWidth-1:0] allOnes = '1;
  localparam logic [dataWidth-1:0] minNeg  = {1'b1, {(dataWidth-1){1'b0}}};
  localparam logic [dataWidth-1:0] maxPos  = {1'b0, {(dataWidth-1){1'b1}}};

  logic                 clk;
  logic                 arstN;
  logic                 opValid;
  aluCmdT               command;
  logic [dataWidth-1:0] operandA;
  logic [dataWidth-1:0] operandB;
  logic                 resultValid;
  logic [dataWidth-1:0] result;
  logic                 carryOut;
  logic                 overflow;
  logic                 zero;

  int edgeCount;
  int opCount;
  int resultCount;
  int failCount;

  // expected results in issue order, with the cycle each is due
  logic [dataWidth-1:0] expResult[$];
  logic                 expCarry[$];
  logic                 expOverflow[$];
  logic                 expZero[$];
  int                   expDue[$];

  // last strobed outputs, which must hold between strobes
  logic [dataWidth-1:0] heldResult   = '0;
  logic                 heldCarry    = 1'b0;
  logic                 heldOverflow = 1'b0;
  logic                 heldZero     = 1'b0;

  tbClock i_tbClock (
    .clk  (clk),
    .arstN(arstN)
  );

  aluUnit #(
    .dataWidth(dataWidth)
  ) i_aluUnit (
    .clk        (clk),
    .arstN      (arstN),
    .opValid    (opValid),
    .command    (command),
    .operandA   (operandA),
    .operandB   (operandB),
    .resultValid(resultValid),
    .result     (result),
    .carryOut   (carryOut),
    .overflow   (overflow),
    .zero       (zero)
  );

  always @(posedge clk) begin
    edgeCount <= edgeCount + 1;
  end

  task automatic reportMismatch(input string msg);
    failCount++;
    $display("Fail at %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic abortRun(input string msg);
    failCount++;
    $display("Error at %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkResult(input logic [dataWidth-1:0] got,
                             input logic [dataWidth-1:0] want, input string what);
    if (got !== want) begin
      reportMismatch($sformatf("%s is %h, expected %h", what, got, want));
    end
  endtask

  task automatic checkFlags(input logic gotCarry, input logic gotOverflow, input logic gotZero,
                            input logic wantCarry, input logic wantOverflow,
                            input logic wantZero, input string what);
    if ({gotCarry, gotOverflow, gotZero} !== {wantCarry, wantOverflow, wantZero}) begin
      reportMismatch($sformatf("%s c/o/z are %b%b%b, expected %b%b%b", what, gotCarry,
                               gotOverflow, gotZero, wantCarry, wantOverflow, wantZero));
    end
  endtask

  // reference model, queues the expected outcome of one operation
  task automatic modelOp(input aluCmdT cmd, input logic [dataWidth-1:0] a,
                         input logic [dataWidth-1:0] b);
    logic [dataWidth:0]   wide;
    logic [dataWidth-1:0] res;
    logic                 c;
    logic                 v;
    logic                 z;
    c = 1'b0;
    v = 1'b0;
    z = 1'b0;
    case (cmd)
      cmdAdd: begin
        wide = {1'b0, a} + {1'b0, b};
        res  = wide[msb:0];
        c    = wide[dataWidth];
        // same-sign operands whose sum flips sign
        v    = (a[msb] == b[msb]) && (res[msb] != a[msb]);
        z    = (res == '0);
      end
      cmdSub: begin
        wide = {1'b0, a} + {1'b0, ~b} + 1'b1;
        res  = wide[msb:0];
        c    = wide[dataWidth];
        v    = (a[msb] != b[msb]) && (res[msb] != a[msb]);
        z    = (res == '0);
      end
      cmdXor:  res = a ^ b;
      cmdSlt:  res = ($signed(a) < $signed(b)) ? 1 : 0;
      cmdAnd:  res = a & b;
      cmdNand: res = ~(a & b);
      cmdNor:  res = ~(a | b);
      cmdOr:   res = a | b;
      default: res = 'x;
    endcase
    expResult.push_back(res);
    expCarry.push_back(c);
    expOverflow.push_back(v);
    expZero.push_back(z);
    // sampled at the next edge and out two edges later
    expDue.push_back(edgeCount + 3);
  endtask

  function automatic logic [dataWidth-1:0] randomOperand();
    case ($urandom_range(0, 9))
      0:       return '0;
      1:       return allOnes;
      2:       return minNeg;
      3:       return maxPos;
      4:       return 1;
      default: return $urandom;
    endcase
  endfunction

  task automatic nextDriveSlot();
    @(posedge clk);
    #1;
  endtask

  task automatic issueOp(input aluCmdT cmd, input logic [dataWidth-1:0] a,
                         input logic [dataWidth-1:0] b);
    opValid  = 1'b1;
    command  = cmd;
    operandA = a;
    operandB = b;
    modelOp(cmd, a, b);
    opCount++;
  endtask

  // garbage on the data inputs, outputs must not move
  task automatic idleCycle();
    opValid  = 1'b0;
    command  = aluCmdT'($urandom_range(0, 7));
    operandA = $urandom;
    operandB = $urandom;
  endtask

  task automatic directedOp(input aluCmdT cmd, input logic [dataWidth-1:0] a,
                            input logic [dataWidth-1:0] b);
    nextDriveSlot();
    issueOp(cmd, a, b);
  endtask

  // output monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (arstN === 1'b1) begin
      if (resultValid === 1'b1) begin
        if (expDue.size() == 0) begin
          abortRun("resultValid went high with no operation in flight");
        end else begin
          if (expDue[0] != edgeCount) begin
            reportMismatch($sformatf("result due at cycle %0d came at cycle %0d",
                                     expDue[0], edgeCount));
          end
          checkResult(result, expResult[0], "result");
          checkFlags(carryOut, overflow, zero, expCarry[0], expOverflow[0], expZero[0],
                     "flags");
          heldResult   = result;
          heldCarry    = carryOut;
          heldOverflow = overflow;
          heldZero     = zero;
          void'(expResult.pop_front());
          void'(expCarry.pop_front());
          void'(expOverflow.pop_front());
          void'(expZero.pop_front());
          void'(expDue.pop_front());
          resultCount++;
        end
      end else if (resultValid !== 1'b0) begin
        abortRun("resultValid is unknown");
      end else if (expDue.size() > 0 && expDue[0] <= edgeCount) begin
        abortRun("a result did not appear three cycles after its opValid");
      end else begin
        checkResult(result, heldResult, "held result");
        checkFlags(carryOut, overflow, zero, heldCarry, heldOverflow, heldZero, "held flags");
      end
    end
  end

  initial begin
    int                   waitCycles;
    logic [dataWidth-1:0] a;
    logic [dataWidth-1:0] b;
    opValid  = 1'b0;
    command  = cmdAdd;
    operandA = '0;
    operandB = '0;
    void'($urandom(32'hb6bf));

    waitCycles = 0;
    while (arstN !== 1'b1) begin
      @(negedge clk);
      waitCycles++;
      if (waitCycles > resetLimit) begin
        abortRun("reset was not released in time");
      end
    end

    // quiet outputs out of reset
    repeat (3) @(negedge clk);
    if (resultValid !== 1'b0) begin
      reportMismatch("resultValid is high before any opValid");
    end
    checkResult(result, '0, "result after reset");
    checkFlags(carryOut, overflow, zero, 1'b0, 1'b0, 1'b0, "flags after reset");

    // corner cases, back to back
    directedOp(cmdAdd, maxPos, 1);
    directedOp(cmdAdd, minNeg, allOnes);
    directedOp(cmdSub, minNeg, 1);
    directedOp(cmdSub, maxPos, allOnes);
    directedOp(cmdSub, 32'h1234_5678, 32'h1234_5678);
    directedOp(cmdAdd, 1, allOnes);
    directedOp(cmdSlt, minNeg, 1);
    directedOp(cmdSlt, maxPos, allOnes);
    directedOp(cmdAnd, 32'h0f0f_0f0f, 32'hf0f0_f0f0);
    directedOp(cmdXor, 32'hdead_beef, 32'hdead_beef);
    directedOp(cmdNor, allOnes, '0);
    directedOp(cmdNand, allOnes, allOnes);

    for (int i = 0; i < numOps; i++) begin
      nextDriveSlot();
      if ($urandom_range(0, 99) < 70) begin
        a = randomOperand();
        b = ($urandom_range(0, 7) == 0) ? a : randomOperand();
        issueOp(aluCmdT'($urandom_range(0, 7)), a, b);
      end else begin
        idleCycle();
      end
    end
    nextDriveSlot();
    idleCycle();

    waitCycles = 0;
    while (expDue.size() > 0) begin
      @(posedge clk);
      waitCycles++;
      if (waitCycles > drainLimit) begin
        abortRun("the pipeline did not deliver all results");
      end
    end
    repeat (4) @(negedge clk);

    if (opCount != resultCount) begin
      reportMismatch($sformatf("%0d results for %0d operations", resultCount, opCount));
    end

    if (failCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
hw/aluCmdPkg.sv
hw/aluCtrlPkg.sv
hw/aluAdder.sv
hw/aluDecode.sv
hw/aluExecute.sv
hw/aluResult.sv
hw/aluUnit.sv
testbench/tbClock.sv
testbench/tbAluUnit.sv
